// File: tb.f
hw/board_pkg.sv
hw/board_status.sv
hw/spi_flash_reader.sv
hw/boot_sequencer.sv
hw/mcu_board_top.sv
sim/boot_checker.sv
sim/spi_flash_model.sv
sim/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulation stopped with errors"; exit 1; fi; \
	if grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_top.sv
// ################################################
// testbench for the board top with a flash model
// ################################################
`timescale 1ns/1ps

module tb_top;

  import board_pkg::*;

  localparam logic [31:0] SEED = 32'd41999;
  localparam int DRIVE_DELAY = 5;
  // one boot: header and data bits, two sck edges each, plus the gap
  localparam int BOOT_CYCLES = (32 + 32 * int'(BOOT_WORDS)) * 2 * int'(SCK_HALF) + 16;
  localparam int HOLD_MAX    = BOOT_CYCLES + 200;
  localparam int RAND_RUNS   = 4;
  localparam int CYCLE_LIMIT = (2 + RAND_RUNS) * (HOLD_MAX + 50) + 200;

  logic        clk_gen = 1'b0;
  logic        rst_ni;
  logic        fetch_enable;
  logic        boot_select;
  logic        rst_led;
  logic        clk_led;
  logic        exit_value;
  logic        exit_valid;
  logic        flash_cs_n;
  logic        flash_clk;
  wire  [3:0]  flash_dio;
  logic [7:0]  seen_cmd;
  logic [23:0] seen_addr;
  int unsigned txn_cnt;
  logic [7:0]  ref_mem [0:65535];
  logic [31:0] rng;
  int          cycles = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          test_errors = 0;

  mcu_board_top UUT (
    .clk_gen          (clk_gen),
    .rst_ni           (rst_ni),
    .fetch_enable_i   (fetch_enable),
    .boot_select_i    (boot_select),
    .rst_led_o        (rst_led),
    .clk_led_o        (clk_led),
    .exit_value_o     (exit_value),
    .exit_valid_o     (exit_valid),
    .spi_flash_dio_io (flash_dio),
    .spi_flash_cs_o   (flash_cs_n),
    .spi_flash_clk_o  (flash_clk)
  );

  spi_flash_model #(.SEED(SEED)) u_flash (
    .cs_ni     (flash_cs_n),
    .sck_i     (flash_clk),
    .dio_io    (flash_dio),
    .cmd_o     (seen_cmd),
    .addr_o    (seen_addr),
    .txn_cnt_o (txn_cnt)
  );

  bind spi_flash_reader boot_checker u_checker (
    .clk_gen      (clk_gen),
    .rst_ni       (rst_ni),
    .cs_ni        (cs_no),
    .sck_i        (sck_o),
    .mosi_i       (mosi_o),
    .word_valid_i (word_valid_o),
    .done_i       (done_o)
  );

  always #50 clk_gen = !clk_gen;

  always @(posedge clk_gen) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: no result after %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // bit 0 of the sum of big-endian words from the boot address
  function automatic logic predict_exit(input logic [23:0] addr);
    logic [31:0] sum;
    logic [31:0] word;
    logic [15:0] a;
    sum = '0;
    a = addr[15:0];
    for (int j = 0; j < int'(BOOT_WORDS); j++) begin
      word = {ref_mem[a], ref_mem[a + 16'd1], ref_mem[a + 16'd2], ref_mem[a + 16'd3]};
      sum = sum + word;
      a = a + 16'd4;
    end
    return sum[0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic next_cycle();
    @(posedge clk_gen);
    #DRIVE_DELAY;
  endtask

  task automatic check_idle_pins();
    check_value("spi_flash_cs_o", 32'(flash_cs_n), 32'h1);
    check_value("spi_flash_clk_o", 32'(flash_clk), 32'h0);
    // pads only see the pull-down
    check_value("spi_flash_dio_io", 32'(flash_dio), 32'h0);
    check_value("exit_valid_o", 32'(exit_valid), 32'h0);
    check_value("exit_value_o", 32'(exit_value), 32'h0);
    check_value("clk_led_o", 32'(clk_led), 32'h0);
  endtask

  // one boot, fetch held for hold cycles
  task automatic run_boot(input logic sel, input int hold);
    int unsigned txn_before;
    int          n;
    logic [23:0] exp_addr;
    txn_before = txn_cnt;
    exp_addr = sel ? BOOT_ADDR_1 : BOOT_ADDR_0;
    boot_select = sel;
    fetch_enable = 1'b1;
    next_cycle();
    check_value("exit_valid_o", 32'(exit_valid), 32'h0);
    n = 1;
    while (!exit_valid || n < hold) begin
      if (n >= hold) begin
        fetch_enable = 1'b0;
      end
      next_cycle();
      n++;
    end
    fetch_enable = 1'b0;
    next_cycle();
    check_value("command", 32'(seen_cmd), 32'(CMD_READ));
    check_value("address", 32'(seen_addr), 32'(exp_addr));
    check_value("transactions", txn_cnt - txn_before, 32'h1);
    check_value("exit_value_o", 32'(exit_value), 32'(predict_exit(exp_addr)));
  endtask

  initial begin
    logic prev;
    int   n;
    int   hold;
    logic sel;
    rst_ni = 1'b0;
    fetch_enable = 1'b0;
    boot_select = 1'b0;
    rng = SEED;
    for (int i = 0; i < 65536; i++) begin
      rng = xorshift(rng);
      ref_mem[16'(i)] = rng[7:0];
    end

    repeat (5) next_cycle();
    check_idle_pins();
    check_value("rst_led_o", 32'(rst_led), 32'h0);
    repeat (5) next_cycle();
    rst_ni = 1'b1;
    repeat (3) next_cycle();
    check_idle_pins();
    check_value("rst_led_o", 32'(rst_led), 32'h1);
    end_test("reset state");

    prev = clk_led;
    while (clk_led == prev) next_cycle();
    for (int s = 0; s < 2; s++) begin
      prev = clk_led;
      n = 0;
      while (clk_led == prev) begin
        next_cycle();
        n++;
      end
      check_value("clk_led_o spacing", 32'(n), 32'(2 ** (LED_CNT_LEN - 1)));
    end
    end_test("heartbeat");

    run_boot(1'b0, 3);
    end_test("boot select 0");
    // fetch stays high well past the end of the read
    run_boot(1'b1, HOLD_MAX);
    end_test("boot select 1");

    for (int r = 0; r < RAND_RUNS; r++) begin
      rng = xorshift(rng);
      sel = rng[0];
      rng = xorshift(rng);
      hold = 1 + int'(rng % HOLD_MAX);
      run_boot(sel, hold);
    end
    end_test("random boots");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sim/spi_flash_model.sv
// ################################################
// behavioural spi flash, single-bit read command
// ################################################
`timescale 1ns/1ps

module spi_flash_model #(
  parameter logic [31:0] SEED = 32'd1
) (
  input  logic        cs_ni,
  input  logic        sck_i,
  inout  wire  [3:0]  dio_io,
  output logic [7:0]  cmd_o,
  output logic [23:0] addr_o,
  output int unsigned txn_cnt_o
);

  logic [7:0]  mem [0:65535];
  logic [31:0] hdr_q;
  logic [31:0] fill;
  logic [7:0]  cur_byte;
  logic        out_bit;
  int unsigned nbits;
  int unsigned k;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    fill = SEED;
    for (int i = 0; i < 65536; i++) begin
      fill = xorshift(fill);
      mem[16'(i)] = fill[7:0];
    end
  end

  for (genvar i = 0; i < 4; i++) begin : g_pull
    pulldown (dio_io[i]);
  end

  // io1 only after the header, released with chip select
  assign dio_io[1] = (!cs_ni && nbits >= 32) ? out_bit : 1'bz;

  // command and address in on the rising edge
  always @(posedge sck_i or posedge cs_ni) begin
    if (cs_ni) begin
      nbits = 0;
    end else begin
      if (nbits < 32) begin
        hdr_q = {hdr_q[30:0], dio_io[0]};
      end
      nbits = nbits + 1;
      if (nbits == 32) begin
        cmd_o     = hdr_q[31:24];
        addr_o    = hdr_q[23:0];
        txn_cnt_o = txn_cnt_o + 1;
      end
    end
  end

  // next data bit after each falling edge, msb first
  always @(negedge sck_i) begin
    if (!cs_ni && nbits >= 32) begin
      k        = nbits - 32;
      cur_byte = mem[addr_o[15:0] + 16'(k >> 3)];
      out_bit  = cur_byte[3'd7 - 3'(k)];
    end
  end

endmodule

// File: sim/boot_checker.sv
// ################################################
// flash pin protocol assertions for the reader
// ################################################
`timescale 1ns/1ps

module boot_checker (
  input logic clk_gen,
  input logic rst_ni,
  input logic cs_ni,
  input logic sck_i,
  input logic mosi_i,
  input logic word_valid_i,
  input logic done_i
);

  // flash clock rests low while deselected
  a_sck_rest: assert property (@(posedge clk_gen) disable iff (!rst_ni) cs_ni |-> !sck_i)
    else $error("flash clock high while chip select is high");

  // io0 only moves on the falling flash clock edge
  a_mosi_hold: assert property (@(posedge clk_gen) disable iff (!rst_ni)
    (!cs_ni && sck_i) |-> $stable(mosi_i))
    else $error("io0 changed while the flash clock is high");

  a_word_sel: assert property (@(posedge clk_gen) disable iff (!rst_ni)
    word_valid_i |-> !cs_ni)
    else $error("word strobe while chip select is high");

  // done only once the flash is deselected
  a_done_sel: assert property (@(posedge clk_gen) disable iff (!rst_ni) done_i |-> cs_ni)
    else $error("done pulse while chip select is low");

endmodule

// File: hw/mcu_board_top.sv
// ################################################
// board top: status LEDs, boot controller and the
// QSPI flash pads
// ################################################
`timescale 1ns/1ps

module mcu_board_top (
  input  logic       clk_gen,
  input  logic       rst_ni,
  input  logic       fetch_enable_i,
  input  logic       boot_select_i,
  output logic       rst_led_o,
  output logic       clk_led_o,
  output logic       exit_value_o,
  output logic       exit_valid_o,
  inout  wire  [3:0] spi_flash_dio_io,
  output logic       spi_flash_cs_o,
  output logic       spi_flash_clk_o
);

  import board_pkg::*;

  logic        rst_sync_n;
  logic        rd_start;
  flash_addr_t rd_addr;
  word_cnt_t   rd_count;
  flash_word_t rd_word;
  logic        rd_word_valid;
  logic        rd_done;
  logic        mosi;
  logic        mosi_oe;
  logic [3:0]  pad_do;
  logic [3:0]  pad_oe;

  board_status u_status (
    .clk_gen     (clk_gen),
    .rst_ni      (rst_ni),
    .rst_sync_no (rst_sync_n),
    .rst_led_o   (rst_led_o),
    .clk_led_o   (clk_led_o)
  );

  boot_sequencer u_seq (
    .clk_gen         (clk_gen),
    .rst_ni          (rst_sync_n),
    .fetch_enable_i  (fetch_enable_i),
    .boot_select_i   (boot_select_i),
    .rd_start_o      (rd_start),
    .rd_addr_o       (rd_addr),
    .rd_count_o      (rd_count),
    .rd_word_i       (rd_word),
    .rd_word_valid_i (rd_word_valid),
    .rd_done_i       (rd_done),
    .exit_value_o    (exit_value_o),
    .exit_valid_o    (exit_valid_o)
  );

  spi_flash_reader u_reader (
    .clk_gen      (clk_gen),
    .rst_ni       (rst_sync_n),
    .start_i      (rd_start),
    .addr_i       (rd_addr),
    .count_i      (rd_count),
    .miso_i       (spi_flash_dio_io[1]),
    .mosi_o       (mosi),
    .mosi_oe_o    (mosi_oe),
    .cs_no        (spi_flash_cs_o),
    .sck_o        (spi_flash_clk_o),
    .word_o       (rd_word),
    .word_valid_o (rd_word_valid),
    .done_o       (rd_done)
  );

  // single-bit mode, only io0 is ever driven
  assign pad_do = {3'b000, mosi};
  assign pad_oe = {3'b000, mosi_oe};

  for (genvar i = 0; i < 4; i++) begin : g_pad
    assign spi_flash_dio_io[i] = pad_oe[i] ? pad_do[i] : 1'bz;
  end

endmodule

// File: hw/boot_sequencer.sv
// ################################################
// boot sequencer: starts a flash read, sums the
// words and holds the exit result
// ################################################
`timescale 1ns/1ps

module boot_sequencer (
  input  logic                   clk_gen,
  input  logic                   rst_ni,
  input  logic                   fetch_enable_i,
  input  logic                   boot_select_i,
  output logic                   rd_start_o,
  output board_pkg::flash_addr_t rd_addr_o,
  output board_pkg::word_cnt_t   rd_count_o,
  input  board_pkg::flash_word_t rd_word_i,
  input  logic                   rd_word_valid_i,
  input  logic                   rd_done_i,
  output logic                   exit_value_o,
  output logic                   exit_valid_o
);

  import board_pkg::*;

  seq_state_t  state_q;
  logic        fetch_q;
  logic        fetch_rise;
  logic        start_q;
  flash_addr_t addr_q;
  flash_word_t sum_q;
  logic        exit_value_q;
  logic        exit_valid_q;

  assign fetch_rise = fetch_enable_i && !fetch_q;

  always_ff @(posedge clk_gen or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= SEQ_IDLE;
      fetch_q      <= 1'b0;
      start_q      <= 1'b0;
      exit_value_q <= 1'b0;
      exit_valid_q <= 1'b0;
    end else begin
      fetch_q <= fetch_enable_i;
      start_q <= 1'b0;
      case (state_q)
        SEQ_IDLE, SEQ_DONE: begin
          if (fetch_rise) begin
            state_q      <= SEQ_READ;
            start_q      <= 1'b1;
            exit_valid_q <= 1'b0;
          end
        end
        SEQ_READ: begin
          // only bit 0 leaves the board
          if (rd_done_i) begin
            state_q      <= SEQ_DONE;
            exit_valid_q <= 1'b1;
            exit_value_q <= sum_q[0];
          end
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  // start address and checksum
  always_ff @(posedge clk_gen) begin
    if (state_q != SEQ_READ && fetch_rise) begin
      addr_q <= boot_select_i ? BOOT_ADDR_1 : BOOT_ADDR_0;
      sum_q  <= '0;
    end else if (state_q == SEQ_READ && rd_word_valid_i) begin
      sum_q <= sum_q + rd_word_i;
    end
  end

  assign rd_start_o   = start_q;
  assign rd_addr_o    = addr_q;
  assign rd_count_o   = word_cnt_t'(BOOT_WORDS);
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

endmodule

// File: hw/spi_flash_reader.sv
// ################################################
// spi mode-0 master, one read command followed by
// a stream of 32-bit words
// ################################################
`timescale 1ns/1ps

module spi_flash_reader (
  input  logic                   clk_gen,
  input  logic                   rst_ni,
  input  logic                   start_i,
  input  board_pkg::flash_addr_t addr_i,
  input  board_pkg::word_cnt_t   count_i,
  input  logic                   miso_i,
  output logic                   mosi_o,
  output logic                   mosi_oe_o,
  output logic                   cs_no,
  output logic                   sck_o,
  output board_pkg::flash_word_t word_o,
  output logic                   word_valid_o,
  output logic                   done_o
);

  import board_pkg::*;

  rd_state_t            state_q;
  logic                 cs_n_q;
  logic                 sck_q;
  logic [SCK_DIV_W-1:0] div_q;
  logic [4:0]           bit_q;
  word_cnt_t            words_q;
  logic                 word_valid_q;
  logic                 done_q;
  logic [31:0]          tx_q;
  flash_word_t          rx_q;
  logic                 tick;

  // end of a flash clock half period
  assign tick = (div_q == SCK_DIV_W'(SCK_HALF - 1));

  always_ff @(posedge clk_gen or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= RD_IDLE;
      cs_n_q       <= 1'b1;
      sck_q        <= 1'b0;
      div_q        <= '0;
      bit_q        <= '0;
      words_q      <= '0;
      word_valid_q <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      word_valid_q <= 1'b0;
      done_q       <= 1'b0;
      if (state_q != RD_IDLE) begin
        div_q <= tick ? '0 : div_q + 1'b1;
      end
      case (state_q)
        RD_IDLE: begin
          if (start_i) begin
            state_q <= RD_CMD;
            cs_n_q  <= 1'b0;
            div_q   <= '0;
            bit_q   <= '0;
            words_q <= count_i;
          end
        end
        RD_CMD: begin
          if (tick) begin
            sck_q <= !sck_q;
            // command and address advance on the falling edge
            if (sck_q) begin
              if (bit_q == 5'd31) begin
                state_q <= RD_DATA;
                bit_q   <= '0;
              end else begin
                bit_q <= bit_q + 1'b1;
              end
            end
          end
        end
        RD_DATA: begin
          if (tick) begin
            sck_q <= !sck_q;
            if (!sck_q) begin
              if (bit_q == 5'd31) begin
                word_valid_q <= 1'b1;
                words_q      <= words_q - 1'b1;
                bit_q        <= '0;
              end else begin
                bit_q <= bit_q + 1'b1;
              end
            end else if (words_q == '0) begin
              // clock back to rest, deselect the flash
              state_q <= RD_GAP;
              cs_n_q  <= 1'b1;
              bit_q   <= '0;
            end
          end
        end
        RD_GAP: begin
          if (tick) begin
            if (bit_q == 5'd1) begin
              state_q <= RD_IDLE;
              done_q  <= 1'b1;
            end else begin
              bit_q <= bit_q + 1'b1;
            end
          end
        end
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  // shift registers
  always_ff @(posedge clk_gen) begin
    if (state_q == RD_IDLE && start_i) begin
      tx_q <= {CMD_READ, addr_i};
    end else if (state_q == RD_CMD && tick && sck_q) begin
      tx_q <= {tx_q[30:0], 1'b0};
    end
    // sample on the rising edge
    if (state_q == RD_DATA && tick && !sck_q) begin
      rx_q <= {rx_q[30:0], miso_i};
    end
  end

  assign mosi_o       = tx_q[31];
  assign mosi_oe_o    = !cs_n_q;
  assign cs_no        = cs_n_q;
  assign sck_o        = sck_q;
  assign word_o       = rx_q;
  assign word_valid_o = word_valid_q;
  assign done_o       = done_q;

endmodule

// File: hw/board_status.sv
// ################################################
// board status: reset synchronizer, reset LED and
// heartbeat LED counter
// ################################################
`timescale 1ns/1ps

module board_status (
  input  logic clk_gen,
  input  logic rst_ni,
  output logic rst_sync_no,
  output logic rst_led_o,
  output logic clk_led_o
);

  import board_pkg::*;

  logic                   rst_meta_q;
  logic                   rst_sync_q;
  logic [LED_CNT_LEN-1:0] led_cnt_q;

  // asserts at once, releases on the second edge
  always_ff @(posedge clk_gen or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_meta_q <= 1'b0;
      rst_sync_q <= 1'b0;
    end else begin
      rst_meta_q <= 1'b1;
      rst_sync_q <= rst_meta_q;
    end
  end

  assign rst_sync_no = rst_sync_q;
  assign rst_led_o   = rst_sync_q;

  // free-running heartbeat counter
  always_ff @(posedge clk_gen or negedge rst_sync_q) begin
    if (!rst_sync_q) begin
      led_cnt_q <= '0;
    end else begin
      led_cnt_q <= led_cnt_q + 1'b1;
    end
  end

  assign clk_led_o = led_cnt_q[LED_CNT_LEN-1];

endmodule

// File: hw/board_pkg.sv
// ################################################
// shared widths, flash command and boot constants
// ################################################

package board_pkg;

  // flash byte address and data word
  typedef logic [23:0] flash_addr_t;
  typedef logic [31:0] flash_word_t;
  typedef logic [3:0]  word_cnt_t;

  // standard single-bit read
  localparam logic [7:0] CMD_READ = 8'h03;

  localparam flash_addr_t BOOT_ADDR_0 = 24'h000100;
  localparam flash_addr_t BOOT_ADDR_1 = 24'h004000;
  localparam int unsigned BOOT_WORDS  = 8;

  // flash clock divider, clk_gen cycles per half period
  localparam int unsigned SCK_HALF  = 2;
  localparam int unsigned SCK_DIV_W = (SCK_HALF > 1) ? $clog2(SCK_HALF) : 1;

  // small so that the heartbeat toggles in simulation
  localparam int unsigned LED_CNT_LEN = 6;

  typedef enum logic [1:0] {SEQ_IDLE, SEQ_READ, SEQ_DONE} seq_state_t;
  typedef enum logic [1:0] {RD_IDLE, RD_CMD, RD_DATA, RD_GAP} rd_state_t;

endpackage
